// ==== files.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/error_monitor.sv
logic/inflight_counter.sv
logic/pc_gen.sv
logic/fetch_ctrl.sv
logic/fetch_queue.sv
logic/fetch_front.sv
test/tb_fetch_front.sv

// ==== test/tb_fetch_front.sv ====
// testbench for the fetch front end
// random-latency sram model, table of consume/flush/error rows, in-order pc checks

`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_fetch_front;

    localparam int ROWS = 10;

    // one row of stimulus
    typedef struct packed {
        logic [7:0]     count;      // instructions to consume
        logic [7:0]     stall_pct;  // chance of next_allowin_i low
        logic           flush;
        fetch_pkg::pc_t target;
        logic [1:0]     error;      // 1 inst cache, 2 data cache
    } row_t;

    logic clk;
    logic rst_i;
    logic inst_sram_req_o;
    fetch_pkg::sram_tag_t inst_sram_tag_o;
    fetch_pkg::sram_index_t inst_sram_index_o;
    fetch_pkg::sram_offset_t inst_sram_offset_o;
    logic inst_sram_addr_ok_i;
    logic inst_sram_data_ok_i;
    fetch_pkg::sram_rdata_t inst_sram_rdata_i;
    logic flush_i;
    fetch_pkg::pc_t flush_pc_i;
    logic next_allowin_i;
    logic inst_valid_o;
    fetch_pkg::fetch_entry_t inst_entry_o;
    logic inst_cache_error_i;
    logic data_cache_error_i;
    logic error_o;

    row_t rows [ROWS];
    fetch_pkg::pc_t resp_pc_q [$];
    int unsigned resp_due_q [$];
    fetch_pkg::pc_t exp_pc;
    fetch_pkg::pc_t exp_fetch_pc;
    int unsigned consumed;
    int unsigned cycles;
    int unsigned timeout_cycles;

    fetch_front uut (
        .clk                 (clk),
        .rst_i               (rst_i),
        .inst_sram_req_o     (inst_sram_req_o),
        .inst_sram_tag_o     (inst_sram_tag_o),
        .inst_sram_index_o   (inst_sram_index_o),
        .inst_sram_offset_o  (inst_sram_offset_o),
        .inst_sram_addr_ok_i (inst_sram_addr_ok_i),
        .inst_sram_data_ok_i (inst_sram_data_ok_i),
        .inst_sram_rdata_i   (inst_sram_rdata_i),
        .flush_i             (flush_i),
        .flush_pc_i          (flush_pc_i),
        .next_allowin_i      (next_allowin_i),
        .inst_valid_o        (inst_valid_o),
        .inst_entry_o        (inst_entry_o),
        .inst_cache_error_i  (inst_cache_error_i),
        .data_cache_error_i  (data_cache_error_i),
        .error_o             (error_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("timeout after %0d cycles, fetch stopped making progress", cycles);
            abort_run();
        end
    end

    // drive inputs after the edge and sample at the falling edge
    task automatic run_cycle(input logic rst, input logic allow, input logic do_flush,
                             input fetch_pkg::pc_t target, input logic [1:0] err,
                             input logic orphan);
        fetch_pkg::pc_t base;
        fetch_pkg::inst_t exp_inst;
        @(posedge clk);
        #1;
        rst_i               = rst;
        next_allowin_i      = allow;
        flush_i             = do_flush;
        flush_pc_i          = target;
        inst_cache_error_i  = (err == 2'd1);
        data_cache_error_i  = (err == 2'd2);
        inst_sram_addr_ok_i = ($urandom % 4) != 0;
        inst_sram_data_ok_i = 1'b0;
        inst_sram_rdata_i   = '0;
        if (rst) begin
            resp_pc_q.delete();
            resp_due_q.delete();
        end else if (orphan) begin
            inst_sram_data_ok_i = 1'b1;
        end else if (resp_pc_q.size() != 0 && resp_due_q[0] <= cycles) begin
            // low word belongs to the aligned pc
            base = {resp_pc_q[0][31:3], 3'b000};
            inst_sram_data_ok_i = 1'b1;
            inst_sram_rdata_i   = {~(base + 32'd4), ~base};
            void'(resp_pc_q.pop_front());
            void'(resp_due_q.pop_front());
        end
        @(negedge clk);
        if (!rst_i) begin
            if (inst_sram_req_o && inst_sram_addr_ok_i) begin
                check_value("inst_sram_tag_o", inst_sram_tag_o, exp_fetch_pc[31:12]);
                check_value("inst_sram_index_o", inst_sram_index_o, exp_fetch_pc[11:4]);
                check_value("inst_sram_offset_o", inst_sram_offset_o, exp_fetch_pc[3:0]);
                resp_pc_q.push_back(exp_fetch_pc);
                resp_due_q.push_back(cycles + ($urandom % 3) + 1);
                exp_fetch_pc = {exp_fetch_pc[31:3], 3'b000} + 32'd8;
            end
            if (inst_valid_o && next_allowin_i) begin
                exp_inst = ~exp_pc;
                check_value("inst_entry_o.pc", inst_entry_o.pc, exp_pc);
                check_value("inst_entry_o.inst", inst_entry_o.inst, exp_inst);
                exp_pc   = exp_pc + 32'd4;
                consumed = consumed + 1;
            end
        end
    endtask

    task automatic apply_reset(input logic orphan);
        exp_pc       = `FETCH_RESET_PC;
        exp_fetch_pc = `FETCH_RESET_PC;
        for (int i = 0; i < 3; i++) begin
            run_cycle(1'b1, 1'b0, 1'b0, '0, 2'd0, 1'b0);
            // outputs settle once the first reset edge is seen
            if (i > 0) begin
                check_value("inst_sram_req_o", inst_sram_req_o, 0);
                check_value("inst_valid_o", inst_valid_o, 0);
                check_value("error_o", error_o, 0);
            end
        end
        run_cycle(1'b0, 1'b0, 1'b0, '0, 2'd0, orphan);
        check_value("inst_sram_req_o", inst_sram_req_o, 0);
        check_value("inst_valid_o", inst_valid_o, 0);
        check_value("error_o", error_o, 0);
    endtask

    // error_o stays set and no request goes out until reset
    task automatic check_halted(input int unsigned n);
        repeat (n) begin
            run_cycle(1'b0, 1'b0, 1'b0, '0, 2'd0, 1'b0);
            check_value("error_o", error_o, 1);
            check_value("inst_sram_req_o", inst_sram_req_o, 0);
        end
    endtask

    initial begin
        int unsigned total;
        int unsigned goal;
        rst_i               = 1'b1;
        inst_sram_addr_ok_i = 1'b0;
        inst_sram_data_ok_i = 1'b0;
        inst_sram_rdata_i   = '0;
        flush_i             = 1'b0;
        flush_pc_i          = '0;
        next_allowin_i      = 1'b0;
        inst_cache_error_i  = 1'b0;
        data_cache_error_i  = 1'b0;
        consumed            = 0;
        cycles              = 0;
        void'($urandom(32'h7a43_cfd0));

        rows[0] = '{8'd12, 8'd0,  1'b0, 32'h0000_0000, 2'd0};
        rows[1] = '{8'd10, 8'd50, 1'b0, 32'h0000_0000, 2'd0};
        rows[2] = '{8'd6,  8'd25, 1'b1, 32'h1c00_1000, 2'd0};
        rows[3] = '{8'd8,  8'd40, 1'b1, 32'h1c00_2004, 2'd0};
        rows[4] = '{8'd16, 8'd70, 1'b0, 32'h0000_0000, 2'd0};
        rows[5] = '{8'd4,  8'd30, 1'b0, 32'h0000_0000, 2'd1};
        rows[6] = '{8'd10, 8'd20, 1'b0, 32'h0000_0000, 2'd0};
        rows[7] = '{8'd6,  8'd30, 1'b1, 32'h0000_0ffc, 2'd0};
        rows[8] = '{8'd4,  8'd10, 1'b0, 32'h0000_0000, 2'd2};
        rows[9] = '{8'd8,  8'd50, 1'b0, 32'h0000_0000, 2'd0};
        total = 0;
        for (int r = 0; r < ROWS; r++) begin
            total = total + rows[r].count;
        end
        timeout_cycles = total * 10 + 100;

        apply_reset(1'b0);
        // response with nothing outstanding
        apply_reset(1'b1);
        check_halted(2);
        apply_reset(1'b0);

        for (int r = 0; r < ROWS; r++) begin
            if (rows[r].flush) begin
                run_cycle(1'b0, 1'b0, 1'b1, rows[r].target, 2'd0, 1'b0);
                check_value("inst_sram_req_o", inst_sram_req_o, 0);
                exp_pc       = rows[r].target;
                exp_fetch_pc = rows[r].target;
            end
            goal = consumed + rows[r].count;
            while (consumed < goal) begin
                run_cycle(1'b0, ($urandom % 100) >= rows[r].stall_pct, 1'b0, '0, 2'd0, 1'b0);
            end
            if (rows[r].error != 2'd0) begin
                run_cycle(1'b0, 1'b0, 1'b0, '0, rows[r].error, 1'b0);
                check_halted(4);
                apply_reset(1'b0);
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== logic/fetch_front.sv ====
// instruction fetch front end
// issues sram reads, tracks them in order and buffers instructions for decode

`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_front (
    input  logic                       clk,
    input  logic                       rst_i,
    // instruction sram
    output logic                       inst_sram_req_o,
    output fetch_pkg::sram_tag_t       inst_sram_tag_o,
    output fetch_pkg::sram_index_t     inst_sram_index_o,
    output fetch_pkg::sram_offset_t    inst_sram_offset_o,
    input  logic                       inst_sram_addr_ok_i,
    input  logic                       inst_sram_data_ok_i,
    input  fetch_pkg::sram_rdata_t     inst_sram_rdata_i,
    // redirect
    input  logic                       flush_i,
    input  fetch_pkg::pc_t             flush_pc_i,
    // decode side
    input  logic                       next_allowin_i,
    output logic                       inst_valid_o,
    output fetch_pkg::fetch_entry_t    inst_entry_o,
    // error reporting
    input  logic                       inst_cache_error_i,
    input  logic                       data_cache_error_i,
    output logic                       error_o
);

    localparam int OUT_W  = $clog2(`FETCH_MAX_OUTSTANDING + 1);
    localparam int FREE_W = $clog2(`FETCH_QUEUE_DEPTH + 1);

    logic                   req;
    logic                   accept;
    fetch_pkg::sram_addr_t  fetch_addr;
    logic [OUT_W-1:0]       outstanding;
    logic [OUT_W-1:0]       discard;
    logic                   keep;
    logic                   orphan;
    logic [FREE_W-1:0]      free_slots;
    logic                   halt;

    // a request is taken when the sram acknowledges the address
    assign accept = req & inst_sram_addr_ok_i;

    assign inst_sram_req_o    = req;
    assign inst_sram_tag_o    = fetch_addr.tag;
    assign inst_sram_index_o  = fetch_addr.index;
    assign inst_sram_offset_o = fetch_addr.offset;
    assign error_o            = halt;

    fetch_ctrl u_fetch_ctrl (
        .clk           (clk),
        .rst_i         (rst_i),
        .halt_i        (halt),
        .flush_i       (flush_i),
        .outstanding_i (outstanding),
        .discard_i     (discard),
        .free_slots_i  (free_slots),
        .req_o         (req)
    );

    pc_gen u_pc_gen (
        .clk          (clk),
        .rst_i        (rst_i),
        .accept_i     (accept),
        .flush_i      (flush_i),
        .flush_pc_i   (flush_pc_i),
        .fetch_addr_o (fetch_addr)
    );

    inflight_counter #(
        .MAX_OUTSTANDING (`FETCH_MAX_OUTSTANDING)
    ) u_inflight_counter (
        .clk           (clk),
        .rst_i         (rst_i),
        .accept_i      (accept),
        .data_ok_i     (inst_sram_data_ok_i),
        .flush_i       (flush_i),
        .outstanding_o (outstanding),
        .discard_o     (discard),
        .keep_o        (keep),
        .orphan_o      (orphan)
    );

    fetch_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk            (clk),
        .rst_i          (rst_i),
        .accept_i       (accept),
        .fetch_addr_i   (fetch_addr),
        .keep_i         (keep),
        .data_ok_i      (inst_sram_data_ok_i),
        .rdata_i        (inst_sram_rdata_i),
        .flush_i        (flush_i),
        .next_allowin_i (next_allowin_i),
        .free_slots_o   (free_slots),
        .inst_valid_o   (inst_valid_o),
        .inst_entry_o   (inst_entry_o)
    );

    error_monitor u_error_monitor (
        .clk                (clk),
        .rst_i              (rst_i),
        .inst_cache_error_i (inst_cache_error_i),
        .data_cache_error_i (data_cache_error_i),
        .orphan_i           (orphan),
        .error_o            (halt)
    );

endmodule

// ==== logic/fetch_queue.sv ====
// fetch queue
// pairs each response with its request pc, writes up to two entries,
// hands them to decode one per cycle

`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_queue #(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         accept_i,
    input  fetch_pkg::sram_addr_t        fetch_addr_i,
    input  logic                         keep_i,
    input  logic                         data_ok_i,
    input  fetch_pkg::sram_rdata_t       rdata_i,
    input  logic                         flush_i,
    input  logic                         next_allowin_i,
    output logic [$clog2(DEPTH + 1)-1:0] free_slots_o,
    output logic                         inst_valid_o,
    output fetch_pkg::fetch_entry_t      inst_entry_o
);

    localparam int CW        = $clog2(DEPTH + 1);
    localparam int AW        = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int REQ_DEPTH = `FETCH_MAX_OUTSTANDING;
    localparam int RW        = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;

    // request pcs, oldest at req_rd_q
    fetch_pkg::pc_t          req_pc_mem [REQ_DEPTH];
    logic [RW-1:0]           req_wr_q;
    logic [RW-1:0]           req_rd_q;

    fetch_pkg::fetch_entry_t entry_mem [DEPTH];
    logic [AW-1:0]           head_q;
    logic [AW-1:0]           tail_q;
    logic [AW-1:0]           tail_nxt;
    logic [AW-1:0]           tail_nxt2;
    logic [CW-1:0]           count_q;

    fetch_pkg::pc_t          resp_pc;
    fetch_pkg::pc_t          resp_base;
    fetch_pkg::fetch_entry_t wr_first;
    fetch_pkg::fetch_entry_t wr_second;
    logic                    wr_en;
    logic [1:0]              wr_cnt;
    logic                    pop;

    assign wr_en = data_ok_i & keep_i;
    assign pop   = inst_valid_o & next_allowin_i;

    assign resp_pc   = req_pc_mem[req_rd_q];
    assign resp_base = {resp_pc[31:3], 3'b000};

    // low word is the aligned pc, high word is pc + 4
    always_comb begin
        if (resp_pc[2]) begin
            wr_first.pc    = resp_pc;
            wr_first.inst  = rdata_i[63:32];
            wr_second      = wr_first;
            wr_cnt         = wr_en ? 2'd1 : 2'd0;
        end else begin
            wr_first.pc    = resp_base;
            wr_first.inst  = rdata_i[31:0];
            wr_second.pc   = resp_base + 32'd4;
            wr_second.inst = rdata_i[63:32];
            wr_cnt         = wr_en ? 2'd2 : 2'd0;
        end
    end

    assign tail_nxt  = (tail_q == AW'(DEPTH - 1)) ? '0 : tail_q + 1'b1;
    assign tail_nxt2 = (tail_nxt == AW'(DEPTH - 1)) ? '0 : tail_nxt + 1'b1;

    // storage
    always_ff @(posedge clk) begin
        if (accept_i) begin
            req_pc_mem[req_wr_q] <= {fetch_addr_i.tag, fetch_addr_i.index, fetch_addr_i.offset};
        end
        if (wr_cnt != 2'd0) begin
            entry_mem[tail_q] <= wr_first;
        end
        if (wr_cnt == 2'd2) begin
            entry_mem[tail_nxt] <= wr_second;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            req_wr_q <= '0;
            req_rd_q <= '0;
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
        end else begin
            if (accept_i) begin
                req_wr_q <= (req_wr_q == RW'(REQ_DEPTH - 1)) ? '0 : req_wr_q + 1'b1;
            end
            if (wr_en) begin
                req_rd_q <= (req_rd_q == RW'(REQ_DEPTH - 1)) ? '0 : req_rd_q + 1'b1;
            end
            if (wr_cnt == 2'd1) begin
                tail_q <= tail_nxt;
            end else if (wr_cnt == 2'd2) begin
                tail_q <= tail_nxt2;
            end
            if (pop) begin
                head_q <= (head_q == AW'(DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            count_q <= count_q + CW'(wr_cnt) - CW'(pop);
        end
    end

    assign free_slots_o = CW'(DEPTH) - count_q;
    assign inst_valid_o = (count_q != '0);
    assign inst_entry_o = entry_mem[head_q];

endmodule

// ==== logic/fetch_ctrl.sv ====
// fetch control FSM
// decides when a read request may go out and stops fetching on error

`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_ctrl (
    input  logic                                          clk,
    input  logic                                          rst_i,
    input  logic                                          halt_i,
    input  logic                                          flush_i,
    input  logic [$clog2(`FETCH_MAX_OUTSTANDING + 1)-1:0] outstanding_i,
    input  logic [$clog2(`FETCH_MAX_OUTSTANDING + 1)-1:0] discard_i,
    input  logic [$clog2(`FETCH_QUEUE_DEPTH + 1)-1:0]     free_slots_i,
    output logic                                          req_o
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;

    logic room_ok;
    logic slot_ok;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::FS_IDLE: begin
                // one quiet cycle after reset
                state_d = halt_i ? fetch_pkg::FS_HALT : fetch_pkg::FS_FETCH;
            end
            fetch_pkg::FS_FETCH: begin
                if (halt_i) begin
                    state_d = fetch_pkg::FS_HALT;
                end
            end
            default: begin
                // only reset leaves halt
                state_d = fetch_pkg::FS_HALT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= fetch_pkg::FS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // every request in flight may still bring two words,
    // so the new one needs its own two slots on top of those
    assign slot_ok = int'(free_slots_i) >= 2 * int'(outstanding_i) + 2;
    assign room_ok = int'(outstanding_i) < `FETCH_MAX_OUTSTANDING;

    // halt_i is checked here too so req drops in the cycle error_o rises
    assign req_o = (state_q == fetch_pkg::FS_FETCH) && !halt_i && !flush_i &&
                   room_ok && (discard_i == '0) && slot_ok;

endmodule

// ==== logic/pc_gen.sv ====
// fetch pc register
// steps by one 8-byte pair per accepted request, reloads on flush

`timescale 1ns/1ps
`include "fetch_settings.svh"

module pc_gen (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  accept_i,
    input  logic                  flush_i,
    input  fetch_pkg::pc_t        flush_pc_i,
    output fetch_pkg::sram_addr_t fetch_addr_o
);

    fetch_pkg::pc_t pc_q;
    fetch_pkg::pc_t pc_seq;

    // next pair always starts 8-aligned, even after an odd flush target
    assign pc_seq = {pc_q[31:3], 3'b000} + 32'd8;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (flush_i) begin
            pc_q <= flush_pc_i;
        end else if (accept_i) begin
            pc_q <= pc_seq;
        end
    end

    // cache address fields
    assign fetch_addr_o.tag    = pc_q[31:12];
    assign fetch_addr_o.index  = pc_q[11:4];
    assign fetch_addr_o.offset = pc_q[3:0];

endmodule

// ==== logic/inflight_counter.sv ====
// in-flight request tracking
// counts requests awaiting data and responses to throw away after a flush

`timescale 1ns/1ps
`include "fetch_settings.svh"

module inflight_counter #(
    parameter int MAX_OUTSTANDING = `FETCH_MAX_OUTSTANDING
) (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   accept_i,
    input  logic                                   data_ok_i,
    input  logic                                   flush_i,
    output logic [$clog2(MAX_OUTSTANDING + 1)-1:0] outstanding_o,
    output logic [$clog2(MAX_OUTSTANDING + 1)-1:0] discard_o,
    output logic                                   keep_o,
    output logic                                   orphan_o
);

    localparam int CW = $clog2(MAX_OUTSTANDING + 1);

    logic [CW-1:0] outstanding_q;
    logic [CW-1:0] outstanding_d;
    logic [CW-1:0] discard_q;
    logic [CW-1:0] discard_d;
    logic [CW:0]   pending;

    // everything the sram still owes us
    assign pending = {1'b0, discard_q} + {1'b0, outstanding_q};

    always_comb begin
        outstanding_d = outstanding_q;
        discard_d     = discard_q;
        if (flush_i) begin
            // a response landing in the flush cycle is already gone
            outstanding_d = '0;
            discard_d     = CW'(pending - (data_ok_i && pending != '0));
        end else begin
            if (data_ok_i) begin
                // discarded responses are always the oldest ones
                if (discard_q != '0) begin
                    discard_d = discard_q - 1'b1;
                end else if (outstanding_q != '0) begin
                    outstanding_d = outstanding_q - 1'b1;
                end
            end
            if (accept_i) begin
                outstanding_d = outstanding_d + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            outstanding_q <= '0;
            discard_q     <= '0;
        end else begin
            outstanding_q <= outstanding_d;
            discard_q     <= discard_d;
        end
    end

    assign outstanding_o = outstanding_q;
    assign discard_o     = discard_q;

    // a response now would belong to a live request
    assign keep_o   = !flush_i && (discard_q == '0) && (outstanding_q != '0);
    assign orphan_o = data_ok_i && (pending == '0);

endmodule

// ==== logic/error_monitor.sv ====
// sticky CPU error flag
// any cache error or unexpected response stops fetch until reset

`timescale 1ns/1ps

module error_monitor (
    input  logic clk,
    input  logic rst_i,
    input  logic inst_cache_error_i,
    input  logic data_cache_error_i,
    input  logic orphan_i,
    output logic error_o
);

    logic error_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            error_q <= 1'b0;
        end else begin
            // never cleared once set
            error_q <= error_q | inst_cache_error_i | data_cache_error_i | orphan_i;
        end
    end

    assign error_o = error_q;

endmodule

// ==== logic/fetch_pkg.sv ====
// fetch front-end types
// address split, queue entry and fetch state encoding

package fetch_pkg;

    // instruction address and word
    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;

    // one sram beat, two instruction words
    typedef logic [63:0] sram_rdata_t;

    // pc split as seen by the instruction cache
    typedef logic [19:0] sram_tag_t;
    typedef logic [7:0]  sram_index_t;
    typedef logic [3:0]  sram_offset_t;

    typedef struct packed {
        sram_tag_t    tag;     // pc[31:12]
        sram_index_t  index;   // pc[11:4]
        sram_offset_t offset;  // pc[3:0]
    } sram_addr_t;

    // what decode receives
    typedef struct packed {
        pc_t   pc;
        inst_t inst;
    } fetch_entry_t;

    typedef enum logic [1:0] {
        FS_IDLE  = 2'd0,
        FS_FETCH = 2'd1,
        FS_HALT  = 2'd2
    } fetch_state_e;

endpackage

// ==== logic/fetch_settings.svh ====
// fetch front-end constants
// reset vector, fetch queue depth and the limit on requests in flight

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h1c00_0000

// entries in the fetch queue, each one instruction
`define FETCH_QUEUE_DEPTH 8

// accepted requests still waiting for data_ok
`define FETCH_MAX_OUTSTANDING 2

`endif
